//--- verilog.f
verilog/core_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/register_file.sv
verilog/alu_stage.sv
verilog/rv32_core.sv
verification/core_props.sv
verification/core_tb.sv

//--- Makefile
# Verilator build and run for the RV32I core testbench.
# Any variable can be overridden on the command line, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
TOP        ?= core_tb
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= all tests passed
LINT_FLAGS ?= --timing --assert
VFLAGS     ?= --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/core_tb.sv
`timescale 1ns/1ps

module core_tb import core_pkg::*; ();

    // One program step with the writeback it should produce.
    typedef struct packed {
        instr_t      instr;
        logic        writes;
        logic [4:0]  rd;
        logic [31:0] value;
    } entry_t;

    logic        clk;
    logic        rst_n;
    logic        imem_en;
    logic [29:0] imem_addr;
    instr_t      imem_data;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic [31:0] dec_pc;

    // Instruction memory model and the word address of the request in flight.
    instr_t      imem [0:255];
    logic [7:0]  pending_addr = '0;
    entry_t      program_q [$];
    int          cycle_count = 0;
    int          cycle_limit = 0;

    rv32_core dut0 (.*);

    bind rv32_core core_props props0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .imem_en  (imem_en),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    always #4 clk = ~clk;

    // Instruction encoders for the three layouts used by the program.
    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic logic [31:0] i_word(input logic [6:0] op, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] u_word(input logic [6:0] op, input logic [4:0] rd,
                                           input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    task automatic add_entry(input logic [31:0] word, input logic writes,
                             input logic [4:0] rd, input logic [31:0] value);
        entry_t e;
        e.instr  = word;
        e.writes = writes;
        e.rd     = rd;
        e.value  = value;
        program_q.push_back(e);
    endtask

    // Prints the reason, then the fail message, and stops the run.
    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, expected));
        end
    endtask

    // Advances at least one cycle, so back-to-back writebacks are each seen once.
    task automatic wait_writeback();
        do begin
            @(negedge clk);
        end while (wb_valid !== 1'b1);
    endtask

    // Expected values are worked out by hand. Entry k sits at pc 4*k.
    task automatic load_program();
        // Immediate forms, then LUI and AUIPC (entry 11, pc 0x2c).
        add_entry(i_word(op_imm, f3_add, 5'd1, 5'd0, 12'd100), 1'b1, 5'd1, 32'h0000_0064);
        add_entry(i_word(op_imm, f3_add, 5'd2, 5'd0, 12'hff9), 1'b1, 5'd2, 32'hffff_fff9);
        add_entry(i_word(op_imm, f3_slt, 5'd3, 5'd2, 12'hffa), 1'b1, 5'd3, 32'h0000_0001);
        add_entry(i_word(op_imm, f3_sltu, 5'd4, 5'd2, 12'd5), 1'b1, 5'd4, 32'h0000_0000);
        add_entry(i_word(op_imm, f3_xor, 5'd5, 5'd1, 12'h0f0), 1'b1, 5'd5, 32'h0000_0094);
        add_entry(i_word(op_imm, f3_or, 5'd6, 5'd1, 12'h703), 1'b1, 5'd6, 32'h0000_0767);
        add_entry(i_word(op_imm, f3_and, 5'd7, 5'd2, 12'h0ff), 1'b1, 5'd7, 32'h0000_00f9);
        add_entry(i_word(op_imm, f3_sll, 5'd8, 5'd1, 12'h004), 1'b1, 5'd8, 32'h0000_0640);
        add_entry(i_word(op_imm, f3_sr, 5'd9, 5'd2, 12'h004), 1'b1, 5'd9, 32'h0fff_ffff);
        add_entry(i_word(op_imm, f3_sr, 5'd10, 5'd2, 12'h401), 1'b1, 5'd10, 32'hffff_fffc);
        add_entry(u_word(op_lui, 5'd11, 20'habcde), 1'b1, 5'd11, 32'habcd_e000);
        add_entry(u_word(op_auipc, 5'd12, 20'h00001), 1'b1, 5'd12, 32'h0000_102c);
        // Register forms; sub from x0 wraps and sra keeps the sign.
        add_entry(r_word(7'h00, f3_add, 5'd13, 5'd1, 5'd2), 1'b1, 5'd13, 32'h0000_005d);
        add_entry(r_word(7'h20, f3_add, 5'd14, 5'd0, 5'd1), 1'b1, 5'd14, 32'hffff_ff9c);
        add_entry(r_word(7'h00, f3_sll, 5'd15, 5'd1, 5'd3), 1'b1, 5'd15, 32'h0000_00c8);
        add_entry(r_word(7'h00, f3_slt, 5'd16, 5'd2, 5'd1), 1'b1, 5'd16, 32'h0000_0001);
        add_entry(r_word(7'h00, f3_sltu, 5'd17, 5'd2, 5'd1), 1'b1, 5'd17, 32'h0000_0000);
        add_entry(r_word(7'h00, f3_xor, 5'd18, 5'd11, 5'd6), 1'b1, 5'd18, 32'habcd_e767);
        add_entry(r_word(7'h00, f3_sr, 5'd19, 5'd14, 5'd3), 1'b1, 5'd19, 32'h7fff_ffce);
        add_entry(r_word(7'h20, f3_sr, 5'd20, 5'd14, 5'd3), 1'b1, 5'd20, 32'hffff_ffce);
        add_entry(r_word(7'h00, f3_or, 5'd21, 5'd5, 5'd7), 1'b1, 5'd21, 32'h0000_00fd);
        add_entry(r_word(7'h00, f3_and, 5'd22, 5'd11, 5'd9), 1'b1, 5'd22, 32'h0bcd_e000);
        // A chain where every step reads the result just before it.
        add_entry(i_word(op_imm, f3_add, 5'd23, 5'd1, 12'd1), 1'b1, 5'd23, 32'h0000_0065);
        add_entry(r_word(7'h00, f3_add, 5'd23, 5'd23, 5'd23), 1'b1, 5'd23, 32'h0000_00ca);
        add_entry(i_word(op_imm, f3_sll, 5'd24, 5'd23, 12'd2), 1'b1, 5'd24, 32'h0000_0328);
        add_entry(r_word(7'h20, f3_add, 5'd25, 5'd24, 5'd23), 1'b1, 5'd25, 32'h0000_025e);
        add_entry(r_word(7'h00, f3_xor, 5'd25, 5'd25, 5'd24), 1'b1, 5'd25, 32'h0000_0176);
        // Sources written two and five instructions back.
        add_entry(i_word(op_imm, f3_add, 5'd26, 5'd0, 12'h123), 1'b1, 5'd26, 32'h0000_0123);
        add_entry(i_word(op_imm, f3_add, 5'd27, 5'd0, 12'h456), 1'b1, 5'd27, 32'h0000_0456);
        add_entry(r_word(7'h00, f3_add, 5'd28, 5'd26, 5'd27), 1'b1, 5'd28, 32'h0000_0579);
        add_entry(i_word(op_imm, f3_add, 5'd29, 5'd0, 12'h010), 1'b1, 5'd29, 32'h0000_0010);
        add_entry(i_word(op_imm, f3_add, 5'd31, 5'd0, 12'd1), 1'b1, 5'd31, 32'h0000_0001);
        add_entry(r_word(7'h00, f3_add, 5'd30, 5'd26, 5'd29), 1'b1, 5'd30, 32'h0000_0133);
        // A write to x0 and a load, neither of which may write back.
        add_entry(i_word(op_imm, f3_add, 5'd0, 5'd1, 12'd5), 1'b0, 5'd0, 32'h0);
        add_entry(i_word(7'b0000011, 3'b010, 5'd5, 5'd1, 12'd0), 1'b0, 5'd0, 32'h0);
        // x0 still reads zero, and x5 kept its earlier value.
        add_entry(r_word(7'h00, f3_add, 5'd3, 5'd0, 5'd1), 1'b1, 5'd3, 32'h0000_0064);
        add_entry(r_word(7'h20, f3_add, 5'd4, 5'd5, 5'd0), 1'b1, 5'd4, 32'h0000_0094);
    endtask

    // The memory answers on the falling edge after the request was seen.
    always @(negedge clk) begin
        imem_data <= imem[pending_addr];
        if (imem_en) begin
            pending_addr <= imem_addr[7:0];
        end
    end

    // Run limit counted in cycles after reset.
    always @(posedge clk) begin
        if (rst_n) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= cycle_limit) begin
                fail_run("timeout: the expected writebacks did not all arrive");
            end
        end
    end

    // A failed property in the bound checker ends the run on the next clock.
    always @(posedge clk) begin
        if (dut0.props0.fail_count != 0) begin
            fail_run("an assertion in the bound checker failed");
        end
    end

    initial begin
        entry_t      e;
        logic [31:0] nop;
        nop = i_word(op_imm, f3_add, 5'd0, 5'd0, 12'd0);
        clk = 1'b0;
        rst_n = 1'b0;
        imem_data = nop;
        load_program();
        // Everything after the program is a nop.
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < program_q.size()) ? program_q[i].instr : nop;
        end
        cycle_limit = program_q.size() + 40;

        // No writeback may show while reset is held.
        repeat (10) begin
            @(negedge clk);
            check_value("wb_valid during reset", 32'(wb_valid), 32'd0);
        end
        rst_n = 1'b1;

        // Writebacks come in program order, so entry 0 must be the first one.
        // Decode runs two instructions ahead of writeback, so it holds entry i+2.
        foreach (program_q[i]) begin
            e = program_q[i];
            if (e.writes) begin
                wait_writeback();
                check_value($sformatf("wb_rd (entry %0d)", i), 32'(wb_rd), 32'(e.rd));
                check_value($sformatf("wb_data (entry %0d)", i), wb_data, e.value);
                check_value($sformatf("dec_pc (entry %0d)", i), dec_pc, 32'(4 * (i + 2)));
            end
        end

        // The trailing nops retire quietly.
        repeat (5) begin
            @(negedge clk);
            check_value("wb_valid after program", 32'(wb_valid), 32'd0);
        end

        if (dut0.props0.fail_count == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            fail_run("an assertion in the bound checker failed");
        end
    end

endmodule

//--- verification/core_props.sv
`timescale 1ns/1ps

module core_props import core_pkg::*; (
    input logic            clk,
    input logic            rst_n,
    input logic            imem_en,
    input logic            wb_valid,
    input logic [4:0]      wb_rd,
    input logic [xlen-1:0] wb_data
);

    // Number of property failures seen so far.
    int fail_count = 0;

    // Decode drops x0 destinations, so a writeback never names x0.
    wb_not_x0: assert property (@(posedge clk) wb_valid |-> (wb_rd != 5'd0))
        else begin
            fail_count++;
            $error("writeback targets x0");
        end

    // A retiring result is always fully defined.
    wb_data_known: assert property (@(posedge clk) wb_valid |-> !$isunknown(wb_data))
        else begin
            fail_count++;
            $error("writeback data has unknown bits");
        end

    // Both signals come from registers, so they drop one clock after reset is seen.
    quiet_in_reset: assert property (@(posedge clk) !rst_n |=> (!imem_en && !wb_valid))
        else begin
            fail_count++;
            $error("fetch or writeback active during reset");
        end

endmodule

//--- verilog/rv32_core.sv
`timescale 1ns/1ps

module rv32_core import core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    output logic            imem_en,
    output logic [xlen-3:0] imem_addr,
    input  instr_t          imem_data,
    output logic            wb_valid,
    output logic [4:0]      wb_rd,
    output logic [xlen-1:0] wb_data,
    output logic [xlen-1:0] dec_pc
);

    fetch_out_t      fetch_out;
    decode_out_t     decode_out;
    wb_t             wb;
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;

    // The four stages, one per pipeline step.
    // The writeback loops back into the register file and the ALU forwarding path.
    fetch_stage fetch_block (.*);
    decode_stage decode_block (.*);
    register_file register_file_block (.*);
    alu_stage alu_block (.*);

    // The writeback is also made visible at the core boundary.
    assign wb_valid = wb.valid;
    assign wb_rd    = wb.rd;
    assign wb_data  = wb.data;

endmodule

//--- verilog/alu_stage.sv
`timescale 1ns/1ps

module alu_stage import core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  decode_out_t decode_out,
    output wb_t         wb
);

    logic [xlen-1:0] rs1_fwd;
    logic [xlen-1:0] rs2_fwd;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;
    logic [xlen-1:0] result;

    // The previous instruction has not reached the register file yet.
    // Its result is taken straight from the writeback register.
    assign rs1_fwd = (wb.valid && (wb.rd == decode_out.rs1)) ? wb.data : decode_out.rs1_data;
    assign rs2_fwd = (wb.valid && (wb.rd == decode_out.rs2)) ? wb.data : decode_out.rs2_data;

    // AUIPC adds to the pc. LUI reads x0 here, so operand a is zero for it.
    assign op_a  = decode_out.use_pc ? decode_out.pc : rs1_fwd;
    assign op_b  = decode_out.use_imm ? decode_out.imm : rs2_fwd;
    assign shamt = op_b[4:0];

    always_comb begin
        case (decode_out.alu_op)
            alu_add:    result = op_a + op_b;
            alu_sub:    result = op_a - op_b;
            alu_sll:    result = op_a << shamt;
            alu_slt:    result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu:   result = {{(xlen-1){1'b0}}, op_a < op_b};
            alu_xor:    result = op_a ^ op_b;
            alu_srl:    result = op_a >> shamt;
            alu_sra:    result = $signed(op_a) >>> shamt;
            alu_or:     result = op_a | op_b;
            alu_and:    result = op_a & op_b;
            alu_pass_b: result = op_b;
            // Encodings past pass_b are never produced by decode.
            default:    result = '0;
        endcase
    end

    // An instruction that does not write still passes, just without a valid writeback.
    always_ff @(posedge clk) begin
        wb.valid <= decode_out.valid && decode_out.write;
        wb.rd    <= decode_out.rd;
        wb.data  <= result;
        if (!rst_n) begin
            wb.valid <= 1'b0;
        end
    end

endmodule

//--- verilog/register_file.sv
`timescale 1ns/1ps

module register_file import core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [4:0]      rs1_addr,
    input  logic [4:0]      rs2_addr,
    output logic [xlen-1:0] rs1_data,
    output logic [xlen-1:0] rs2_data,
    input  wb_t             wb
);

    // x0 has no storage behind it.
    logic [xlen-1:0] regs [1:31];

    // Write-first read, so a value retiring this cycle is seen by decode.
    // This covers a dependency two instructions apart.
    function automatic logic [xlen-1:0] read_port(input logic [4:0] addr, input wb_t wr,
                                                  input logic [xlen-1:0] stored);
        logic [xlen-1:0] value;
        if (addr == 5'd0) begin
            value = '0;
        end else if (wr.valid && (wr.rd == addr)) begin
            value = wr.data;
        end else begin
            value = stored;
        end
        return value;
    endfunction

    // The write port and the stored word are passed in, so both reads follow them.
    assign rs1_data = read_port(rs1_addr, wb, regs[rs1_addr]);
    assign rs2_data = read_port(rs2_addr, wb, regs[rs2_addr]);

    // Decode never lets a writeback target x0 through.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.rd] <= wb.data;
        end
    end

endmodule

//--- verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  fetch_out_t      fetch_out,
    output logic [4:0]      rs1_addr,
    output logic [4:0]      rs2_addr,
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,
    output decode_out_t     decode_out,
    output logic [xlen-1:0] dec_pc
);

    // Maps funct3 to an ALU operation.
    // The alt flag picks sub over add and sra over srl.
    function automatic alu_op_t func_to_op(input logic [2:0] funct3, input logic alt);
        alu_op_t op;
        case (funct3)
            f3_add:  op = alt ? alu_sub : alu_add;
            f3_sll:  op = alu_sll;
            f3_slt:  op = alu_slt;
            f3_sltu: op = alu_sltu;
            f3_xor:  op = alu_xor;
            f3_sr:   op = alt ? alu_sra : alu_srl;
            f3_or:   op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    instr_t      instr;
    logic [6:0]  opcode;
    logic        is_upper;
    logic        supported;
    decode_out_t dec_next;

    assign instr  = fetch_out.instr;
    assign opcode = instr.r_fmt.opcode;

    // LUI and AUIPC carry immediate bits where rs1 would sit.
    // Reading x0 instead keeps operand a at zero for them.
    assign is_upper = (opcode == op_lui) || (opcode == op_auipc);
    assign rs1_addr = is_upper ? 5'd0 : instr.r_fmt.rs1;
    assign rs2_addr = instr.r_fmt.rs2;

    always_comb begin
        dec_next          = '0;
        supported         = 1'b1;
        dec_next.alu_op   = alu_add;
        dec_next.use_imm  = 1'b0;
        dec_next.use_pc   = 1'b0;
        dec_next.imm      = '0;
        case (opcode)
            op_reg: begin
                dec_next.alu_op = func_to_op(instr.r_fmt.funct3, instr.r_fmt.funct7[5]);
            end
            op_imm: begin
                // Only the right shift reads bit 10 of the immediate as sra.
                dec_next.alu_op  = func_to_op(instr.i_fmt.funct3,
                                              (instr.i_fmt.funct3 == f3_sr) &&
                                              instr.i_fmt.imm12[10]);
                dec_next.use_imm = 1'b1;
                dec_next.imm     = {{20{instr.i_fmt.imm12[11]}}, instr.i_fmt.imm12};
            end
            op_lui: begin
                dec_next.alu_op  = alu_pass_b;
                dec_next.use_imm = 1'b1;
                dec_next.imm     = {instr.u_fmt.imm20, 12'd0};
            end
            op_auipc: begin
                dec_next.use_imm = 1'b1;
                dec_next.use_pc  = 1'b1;
                dec_next.imm     = {instr.u_fmt.imm20, 12'd0};
            end
            default: begin
                supported = 1'b0;
            end
        endcase

        // Unsupported opcodes and x0 targets still retire, just without a write.
        dec_next.valid    = fetch_out.valid;
        dec_next.write    = supported && (instr.r_fmt.rd != 5'd0);
        dec_next.rd       = instr.r_fmt.rd;
        dec_next.rs1      = rs1_addr;
        dec_next.rs2      = rs2_addr;
        dec_next.rs1_data = rs1_data;
        dec_next.rs2_data = rs2_data;
        dec_next.pc       = fetch_out.pc;
    end

    // Only the valid bit is cleared by reset; the rest is payload.
    always_ff @(posedge clk) begin
        decode_out <= dec_next;
        if (!rst_n) begin
            decode_out.valid <= 1'b0;
        end
    end

    // Address of the instruction currently in decode.
    assign dec_pc = fetch_out.pc;

endmodule

//--- verilog/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    output logic            imem_en,
    output logic [xlen-3:0] imem_addr,
    input  instr_t          imem_data,
    output fetch_out_t      fetch_out
);

    // Program counter of the word being requested this cycle.
    logic [xlen-1:0] pc;

    // Address and valid of last cycle's request, aligned with the returned word.
    logic            req_valid;
    logic [xlen-1:0] req_pc;

    // The request enable comes up one cycle after reset is released.
    // The pc only moves once a request has actually been issued.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc        <= '0;
            imem_en   <= 1'b0;
            req_valid <= 1'b0;
        end else begin
            imem_en   <= 1'b1;
            req_valid <= imem_en;
            if (imem_en) begin
                pc <= pc + 32'd4;
            end
        end
    end

    // The request address only tags the returned data.
    always_ff @(posedge clk) begin
        req_pc <= pc;
    end

    // Memory is word addressed, so the byte offset bits are dropped.
    assign imem_addr = pc[xlen-1:2];

    // The memory answers one cycle after the request, so the data pairs with req_pc.
    assign fetch_out.valid = req_valid;
    assign fetch_out.pc    = req_pc;
    assign fetch_out.instr = imem_data;

endmodule

//--- verilog/core_pkg.sv
package core_pkg;

    // Data path width of the integer core.
    localparam int xlen = 32;

    // Major opcodes of the supported RV32I groups.
    localparam logic [6:0] op_reg   = 7'b0110011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;

    // The funct3 field selects the operation within OP and OP-IMM.
    // Add and sub share one code, as do the two right shifts.
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // Operations the ALU stage can perform.
    // The pass_b operation hands operand b through unchanged, which LUI uses.
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_t;

    // Register-register layout.
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // Register-immediate layout.
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // Upper-immediate layout.
    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // One instruction word, seen through each encoding layout.
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        u_fmt_t u_fmt;
    } instr_t;

    // Fetched instruction together with the address it came from.
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        instr_t          instr;
    } fetch_out_t;

    // Decoded instruction with its register operands, as handed to the ALU.
    typedef struct packed {
        logic            valid;
        logic            write;
        alu_op_t         alu_op;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [xlen-1:0] rs1_data;
        logic [xlen-1:0] rs2_data;
        logic            use_imm;
        logic            use_pc;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] pc;
    } decode_out_t;

    // Register writeback.
    typedef struct packed {
        logic            valid;
        logic [4:0]      rd;
        logic [xlen-1:0] data;
    } wb_t;

endpackage
